/* design/panel_pkg.sv */
// Pixel and raster types for the panel side, rasters are limited to 4095 by 4095 and 24-bit color
package panel_pkg;

	// ------------------------------------------------------------------
	// Raster limits
	// ------------------------------------------------------------------
	localparam int HACT_MAX = 4095;
	localparam int VACT_MAX = 4095;

	// 8-pixel checker squares
	localparam int CHECKER_SHIFT = 3;

	// ------------------------------------------------------------------
	// Pixel and pattern types
	// ------------------------------------------------------------------
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	typedef enum logic [1:0] {
		PAT_SOLID   = 2'd0,
		PAT_HRAMP   = 2'd1,
		PAT_CHECKER = 2'd2,
		PAT_BORDER  = 2'd3
	} pat_e;

	// Frame setup latched at launch, 50 bits
	typedef struct packed {
		logic [11:0] hact;
		logic [11:0] vact;
		pat_e        pattern;
		pixel_t      color;
	} frame_cfg_t;

	// Generator output, one pixel plus end of frame flag
	typedef struct packed {
		pixel_t rgb;
		logic   last;
	} pix_beat_t;

endpackage

/* design/mcu_bus_pkg.sv */
// MCU bus operations and strobe timing in pclk cycles, T_HOLD must be at least 2 for frame beats
package mcu_bus_pkg;

	// ------------------------------------------------------------------
	// Bus timing in pclk cycles
	// ------------------------------------------------------------------
	localparam int T_SETUP  = 1;
	localparam int T_STROBE = 2;
	localparam int T_HOLD   = 2;
	localparam int T_READ   = 3;

	// Phase counter width, covers the longest phase above
	localparam int T_CNT_W = 2;

	typedef enum logic [1:0] {
		OP_IDLE      = 2'd0,
		OP_CMD_WRITE = 2'd1,
		OP_REG_READ  = 2'd2,
		OP_FRAME     = 2'd3
	} bus_op_e;

	// Bus outputs, 13 bits
	typedef struct packed {
		logic       csx;
		logic       rdx;
		logic       wrx;
		logic       dcx;
		logic [7:0] data_out;
		logic       data_oe;
	} mcu_pins_t;

	// One launched operation
	typedef struct packed {
		bus_op_e    op;
		logic       dcx;
		logic [7:0] cmd_byte;
	} bus_req_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} byte_beat_t;

endpackage

/* design/panel_regs.sv */
// Zero wait state APB registers that run one bus operation at a time and refuse CTRL writes while busy
`timescale 1ns/1ps

module panel_regs (
	input  logic                  pclk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [7:0]            paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	output mcu_bus_pkg::bus_req_t bus_req,
	output logic                  req_valid,
	output logic                  frame_start,
	output panel_pkg::frame_cfg_t frame_cfg,
	input  logic                  done,
	input  logic [7:0]            rd_byte
);

	import panel_pkg::*;
	import mcu_bus_pkg::*;

	localparam logic [7:0] ADDR_CTRL    = 8'h00;
	localparam logic [7:0] ADDR_CMD     = 8'h04;
	localparam logic [7:0] ADDR_SIZE    = 8'h08;
	localparam logic [7:0] ADDR_PATTERN = 8'h0c;
	localparam logic [7:0] ADDR_STATUS  = 8'h10;

	logic       busy;
	logic [7:0] cmd_byte;
	logic       cmd_dcx;
	logic [7:0] rd_data;
	logic       access;
	logic       mapped;
	logic       ctrl_wr;

	assign pready  = 1'b1;
	assign access  = psel && penable;
	assign mapped  = (paddr == ADDR_CTRL) || (paddr == ADDR_CMD) || (paddr == ADDR_SIZE) ||
		(paddr == ADDR_PATTERN) || (paddr == ADDR_STATUS);
	assign ctrl_wr = access && pwrite && (paddr == ADDR_CTRL);
	assign pslverr = access && (!mapped || (ctrl_wr && busy));

	always_comb
	begin
		case (paddr)
			ADDR_CMD:     prdata = {23'h0, cmd_dcx, cmd_byte};
			ADDR_SIZE:    prdata = {4'h0, frame_cfg.vact, 4'h0, frame_cfg.hact};
			ADDR_PATTERN: prdata = {6'h0, frame_cfg.pattern, frame_cfg.color};
			ADDR_STATUS:  prdata = {16'h0, rd_data, 7'h0, busy};
			default:      prdata = 32'h0;
		endcase
	end

	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy        <= 1'b0;
			cmd_byte    <= 8'h00;
			cmd_dcx     <= 1'b0;
			rd_data     <= 8'h00;
			frame_cfg   <= '0;
			bus_req     <= '0;
			req_valid   <= 1'b0;
			frame_start <= 1'b0;
		end
		else
		begin
			req_valid   <= 1'b0;
			frame_start <= 1'b0;
			if (done)
			begin
				busy <= 1'b0;
				// Keep the byte returned by a read
				if (bus_req.op == OP_REG_READ)
					rd_data <= rd_byte;
			end
			if (access && pwrite)
			begin
				case (paddr)
					ADDR_CMD:
					begin
						cmd_byte <= pwdata[7:0];
						cmd_dcx  <= pwdata[8];
					end
					ADDR_SIZE:
					begin
						frame_cfg.hact <= pwdata[11:0];
						frame_cfg.vact <= pwdata[27:16];
					end
					ADDR_PATTERN:
					begin
						frame_cfg.color   <= pwdata[23:0];
						frame_cfg.pattern <= pat_e'(pwdata[25:24]);
					end
					ADDR_CTRL:
					begin
						if (!busy && pwdata[2:0] != 3'b000)
						begin
							busy              <= 1'b1;
							req_valid         <= 1'b1;
							bus_req.dcx       <= cmd_dcx;
							bus_req.cmd_byte  <= cmd_byte;
							if (pwdata[2])
							begin
								bus_req.op  <= OP_FRAME;
								frame_start <= 1'b1;
							end
							else if (pwdata[1])
								bus_req.op <= OP_REG_READ;
							else
								bus_req.op <= OP_CMD_WRITE;
						end
					end
					default:
					begin
					end
				endcase
			end
		end
	end

endmodule

/* design/pattern_gen.sv */
// Registered raster scanner that emits one pixel per handshake and expects hact and vact above zero
`timescale 1ns/1ps

module pattern_gen (
	input  logic                    pclk,
	input  logic                    rst_n,
	input  logic                    frame_start,
	input  panel_pkg::frame_cfg_t   frame_cfg,
	output panel_pkg::pix_beat_t    pix,
	output logic                    pix_valid,
	input  logic                    pix_ready
);

	import panel_pkg::*;

	localparam int XW = $clog2(HACT_MAX + 1);
	localparam int YW = $clog2(VACT_MAX + 1);

	// Coordinates of the pixel held on the output
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	logic [XW-1:0] nx;
	logic [YW-1:0] ny;
	logic          move;
	logic          x_end;

	function automatic pix_beat_t gen_pixel(
		input logic [XW-1:0] px,
		input logic [YW-1:0] py,
		input frame_cfg_t    cfg
	);
		pix_beat_t pb;
		logic      on_edge;
		on_edge = (px == '0) || (px == cfg.hact - XW'(1)) ||
			(py == '0) || (py == cfg.vact - YW'(1));
		case (cfg.pattern)
			PAT_HRAMP:
				pb.rgb = '{r: px[7:0], g: px[7:0], b: px[7:0]};
			PAT_CHECKER:
				pb.rgb = (px[CHECKER_SHIFT] ^ py[CHECKER_SHIFT]) ? cfg.color : '0;
			PAT_BORDER:
				pb.rgb = on_edge ? 24'hff_ffff : cfg.color;
			default:
				pb.rgb = cfg.color;
		endcase
		pb.last = (px == cfg.hact - XW'(1)) && (py == cfg.vact - YW'(1));
		return pb;
	endfunction

	assign move  = pix_valid && pix_ready;
	assign x_end = (x == frame_cfg.hact - XW'(1));

	// Next raster position, x wraps into the next line
	always_comb
	begin
		if (x_end)
		begin
			nx = '0;
			ny = y + YW'(1);
		end
		else
		begin
			nx = x + XW'(1);
			ny = y;
		end
	end

	// ------------------------------------------------------------------
	// Scan control
	// ------------------------------------------------------------------
	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pix_valid <= 1'b0;
			x         <= '0;
			y         <= '0;
		end
		else if (frame_start)
		begin
			pix_valid <= 1'b1;
			x         <= '0;
			y         <= '0;
		end
		else if (move)
		begin
			if (pix.last)
			begin
				pix_valid <= 1'b0;
			end
			else
			begin
				x <= nx;
				y <= ny;
			end
		end
	end

	// Pixel register, stalls with the counters
	always_ff @(posedge pclk)
	begin
		if (frame_start)
		begin
			pix <= gen_pixel('0, '0, frame_cfg);
		end
		else if (move && !pix.last)
		begin
			pix <= gen_pixel(nx, ny, frame_cfg);
		end
	end

endmodule

/* design/beat_serializer.sv */
// Splits each pixel into red, green and blue byte beats and can take a new pixel as blue leaves
`timescale 1ns/1ps

module beat_serializer (
	input  logic                    pclk,
	input  logic                    rst_n,
	input  panel_pkg::pix_beat_t    pix,
	input  logic                    pix_valid,
	output logic                    pix_ready,
	output mcu_bus_pkg::byte_beat_t beat,
	output logic                    beat_valid,
	input  logic                    beat_ready
);

	import panel_pkg::*;

	pix_beat_t  hold;
	logic [1:0] idx;
	logic       full;
	logic       beat_move;
	logic       blue;

	assign beat_move  = beat_valid && beat_ready;
	assign blue       = (idx == 2'd2);
	assign beat_valid = full;
	assign pix_ready  = !full || (beat_move && blue);

	always_comb
	begin
		case (idx)
			2'd0:    beat.data = hold.rgb.r;
			2'd1:    beat.data = hold.rgb.g;
			default: beat.data = hold.rgb.b;
		endcase
		// Only the blue beat of the frame's final pixel
		beat.last = hold.last && blue;
	end

	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			full <= 1'b0;
			idx  <= 2'd0;
		end
		else if (pix_valid && pix_ready)
		begin
			full <= 1'b1;
			idx  <= 2'd0;
		end
		else if (beat_move)
		begin
			if (blue)
			begin
				full <= 1'b0;
				idx  <= 2'd0;
			end
			else
			begin
				idx <= idx + 2'd1;
			end
		end
	end

	always_ff @(posedge pclk)
	begin
		if (pix_valid && pix_ready)
		begin
			hold <= pix;
		end
	end

endmodule

/* design/mcu_bus_engine.sv */
// 8080 style bus sequencer for one command write, one read or one frame per request, ignores requests while active
`timescale 1ns/1ps

module mcu_bus_engine (
	input  logic                    pclk,
	input  logic                    rst_n,
	input  mcu_bus_pkg::bus_req_t   bus_req,
	input  logic                    req_valid,
	input  mcu_bus_pkg::byte_beat_t beat,
	input  logic                    beat_valid,
	output logic                    beat_ready,
	output mcu_bus_pkg::mcu_pins_t  pins,
	input  logic [7:0]              data_in,
	output logic                    done,
	output logic [7:0]              rd_byte
);

	import mcu_bus_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_SETUP,
		S_WR_LOW,
		S_RD_LOW,
		S_HOLD,
		S_FR_WAIT
	} state_e;

	state_e             state;
	bus_op_e            cur_op;
	logic [T_CNT_W-1:0] cnt;
	logic               last_r;

	// Beats only accepted between strobes
	assign beat_ready = (state == S_FR_WAIT);

	// ------------------------------------------------------------------
	// Bus sequencer
	// ------------------------------------------------------------------
	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state         <= S_IDLE;
			cur_op        <= OP_IDLE;
			cnt           <= '0;
			last_r        <= 1'b0;
			done          <= 1'b0;
			pins.csx      <= 1'b1;
			pins.rdx      <= 1'b1;
			pins.wrx      <= 1'b1;
			pins.dcx      <= 1'b1;
			pins.data_out <= 8'h00;
			pins.data_oe  <= 1'b1;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (req_valid && bus_req.op != OP_IDLE)
					begin
						cur_op   <= bus_req.op;
						pins.csx <= 1'b0;
						pins.dcx <= (bus_req.op == OP_FRAME) ? 1'b1 : bus_req.dcx;
						cnt      <= T_CNT_W'(T_SETUP - 1);
						state    <= S_SETUP;
						if (bus_req.op == OP_CMD_WRITE)
						begin
							pins.data_out <= bus_req.cmd_byte;
						end
						// Panel drives the bus during a read
						if (bus_req.op == OP_REG_READ)
						begin
							pins.data_oe <= 1'b0;
						end
					end
				end
				S_SETUP:
				begin
					if (cnt != '0)
					begin
						cnt <= cnt - T_CNT_W'(1);
					end
					else if (cur_op == OP_REG_READ)
					begin
						pins.rdx <= 1'b0;
						cnt      <= T_CNT_W'(T_READ - 1);
						state    <= S_RD_LOW;
					end
					else if (cur_op == OP_CMD_WRITE)
					begin
						pins.wrx <= 1'b0;
						cnt      <= T_CNT_W'(T_STROBE - 1);
						state    <= S_WR_LOW;
					end
					else
					begin
						state <= S_FR_WAIT;
					end
				end
				S_FR_WAIT:
				begin
					// Counts as the last hold cycle of the previous beat
					if (beat_valid)
					begin
						pins.data_out <= beat.data;
						pins.wrx      <= 1'b0;
						last_r        <= beat.last;
						cnt           <= T_CNT_W'(T_STROBE - 1);
						state         <= S_WR_LOW;
					end
				end
				S_WR_LOW:
				begin
					if (cnt != '0)
					begin
						cnt <= cnt - T_CNT_W'(1);
					end
					else
					begin
						pins.wrx <= 1'b1;
						state    <= S_HOLD;
						if (cur_op == OP_FRAME && !last_r)
							cnt <= T_CNT_W'(T_HOLD - 2);
						else
							cnt <= T_CNT_W'(T_HOLD - 1);
					end
				end
				S_RD_LOW:
				begin
					if (cnt != '0)
					begin
						cnt <= cnt - T_CNT_W'(1);
					end
					else
					begin
						pins.rdx <= 1'b1;
						cnt      <= T_CNT_W'(T_HOLD - 1);
						state    <= S_HOLD;
					end
				end
				S_HOLD:
				begin
					if (cnt != '0)
					begin
						cnt <= cnt - T_CNT_W'(1);
					end
					else if (cur_op == OP_FRAME && !last_r)
					begin
						state <= S_FR_WAIT;
					end
					else
					begin
						// Release the panel and report completion
						pins.csx      <= 1'b1;
						pins.dcx      <= 1'b1;
						pins.data_oe  <= 1'b1;
						pins.data_out <= 8'h00;
						last_r        <= 1'b0;
						cur_op        <= OP_IDLE;
						done          <= 1'b1;
						state         <= S_IDLE;
					end
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Sampled in the last rdx low cycle
	always_ff @(posedge pclk)
	begin
		if (state == S_RD_LOW && cnt == '0)
		begin
			rd_byte <= data_in;
		end
	end

endmodule

/* design/mcu_panel_top.sv */
// APB programmed MCU panel driver with 8-bit split data bus, external logic must merge data_out and data_oe
`timescale 1ns/1ps

module mcu_panel_top (
	input  logic                   pclk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [7:0]             paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output mcu_bus_pkg::mcu_pins_t pins,
	input  logic [7:0]             mcu_data_in
);

	import panel_pkg::*;
	import mcu_bus_pkg::*;

	bus_req_t   bus_req;
	logic       req_valid;
	logic       frame_start;
	frame_cfg_t frame_cfg;
	logic       done;
	logic [7:0] rd_byte;
	pix_beat_t  pix;
	logic       pix_valid;
	logic       pix_ready;
	byte_beat_t beat;
	logic       beat_valid;
	logic       beat_ready;

	panel_regs u_regs (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.bus_req     (bus_req),
		.req_valid   (req_valid),
		.frame_start (frame_start),
		.frame_cfg   (frame_cfg),
		.done        (done),
		.rd_byte     (rd_byte)
	);

	pattern_gen u_pattern_gen (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.frame_cfg   (frame_cfg),
		.pix         (pix),
		.pix_valid   (pix_valid),
		.pix_ready   (pix_ready)
	);

	beat_serializer u_beat_serializer (
		.pclk       (pclk),
		.rst_n      (rst_n),
		.pix        (pix),
		.pix_valid  (pix_valid),
		.pix_ready  (pix_ready),
		.beat       (beat),
		.beat_valid (beat_valid),
		.beat_ready (beat_ready)
	);

	mcu_bus_engine u_bus_engine (
		.pclk       (pclk),
		.rst_n      (rst_n),
		.bus_req    (bus_req),
		.req_valid  (req_valid),
		.beat       (beat),
		.beat_valid (beat_valid),
		.beat_ready (beat_ready),
		.pins       (pins),
		.data_in    (mcu_data_in),
		.done       (done),
		.rd_byte    (rd_byte)
	);

endmodule

/* test/panel_model.sv */
// Behavioral 8080 panel, samples mid-cycle and answers every read with RD_VALUE, no timing checks
`timescale 1ns/1ps

module panel_model #(
	parameter logic [7:0] RD_VALUE = 8'h5a
) (
	input  logic                   pclk,
	input  mcu_bus_pkg::mcu_pins_t pins,
	output logic [7:0]             data_in
);

	// Captured writes as {dcx, data}
	logic [8:0] wr_q[$];
	int         rd_cycles;
	int         csx_rises;
	logic       oe_bad;
	logic       wrx_q;
	logic       csx_q;

	// Panel drives the bus only while the host has released it
	assign data_in = pins.data_oe ? 8'h00 : RD_VALUE;

	initial
	begin
		rd_cycles = 0;
		csx_rises = 0;
		oe_bad    = 1'b0;
		wrx_q     = 1'b1;
		csx_q     = 1'b1;
	end

	// Sampled on the falling clock edge where the bus pins are settled
	always @(negedge pclk)
	begin
		if (pins.wrx && !wrx_q && !pins.csx)
		begin
			wr_q.push_back({pins.dcx, pins.data_out});
		end
		if (!pins.rdx && !pins.csx)
		begin
			rd_cycles = rd_cycles + 1;
			// Bus contention if the host still drives
			if (pins.data_oe)
				oe_bad = 1'b1;
		end
		if (pins.csx && !csx_q)
		begin
			csx_rises = csx_rises + 1;
		end
		wrx_q = pins.wrx;
		csx_q = pins.csx;
	end

endmodule

/* test/tb_mcu_panel.sv */
// Directed testbench for the APB MCU panel driver, frames are 11 by 10 so checker squares wrap once
`timescale 1ns/1ps

module tb_mcu_panel;

	import panel_pkg::*;
	import mcu_bus_pkg::*;

	localparam logic [7:0] ADDR_CTRL     = 8'h00;
	localparam logic [7:0] ADDR_CMD      = 8'h04;
	localparam logic [7:0] ADDR_SIZE     = 8'h08;
	localparam logic [7:0] ADDR_PATTERN  = 8'h0c;
	localparam logic [7:0] ADDR_STATUS   = 8'h10;
	localparam logic [7:0] ADDR_BAD      = 8'h40;
	localparam logic [7:0] RD_VALUE      = 8'hc3;
	localparam int         RD_LOW_CYCLES = 3;
	localparam int         FRAME_H       = 11;
	localparam int         FRAME_V       = 10;
	localparam int         FRAME_BYTES   = 3 * FRAME_H * FRAME_V;
	localparam int         N_FRAMES      = 5;
	localparam int         POLL_LIMIT    = 2000;
	localparam int         WATCHDOG_CYC  = N_FRAMES * FRAME_H * FRAME_V * 16 + 4000;

	logic        pclk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	mcu_pins_t   pins;
	logic [7:0]  mcu_data_in;

	logic [31:0] rng;
	string       cur_test;
	int          errors;
	int          test_errors;
	int          tests_run;

	mcu_panel_top u_dut (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.pins        (pins),
		.mcu_data_in (mcu_data_in)
	);

	panel_model #(.RD_VALUE(RD_VALUE)) u_model (
		.pclk    (pclk),
		.pins    (pins),
		.data_in (mcu_data_in)
	);

	initial
	begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;
	end

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] t;
		t = s ^ (s << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	// Reference pattern, straight from the pattern rules
	function automatic logic [23:0] expected_rgb(input int x, input int y, input pat_e pat,
		input logic [23:0] color);
		logic [23:0] rgb;
		case (pat)
			PAT_HRAMP:
				rgb = {3{x[7:0]}};
			PAT_CHECKER:
				rgb = (((x >> CHECKER_SHIFT) ^ (y >> CHECKER_SHIFT)) & 1) != 0 ? color : 24'h0;
			PAT_BORDER:
				rgb = (x == 0 || y == 0 || x == FRAME_H - 1 || y == FRAME_V - 1) ? 24'hffffff
					: color;
			default:
				rgb = color;
		endcase
		return rgb;
	endfunction

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("error %s %s: expected %h actual %h", cur_test, what, expected, actual);
			errors      = errors + 1;
			test_errors = test_errors + 1;
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
		tests_run   = tests_run + 1;
	endtask

	task automatic end_test();
		$display("%s finished with %0d errors", cur_test, test_errors);
	endtask

	// Zero wait state access, response sampled mid access phase
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge pclk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge pclk);
		penable <= 1'b1;
		@(negedge pclk);
		err = pslverr;
		compare("pready", 32'h1, 32'(pready));
		@(posedge pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge pclk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge pclk);
		penable <= 1'b1;
		@(negedge pclk);
		data = prdata;
		err  = pslverr;
		compare("pready", 32'h1, 32'(pready));
		@(posedge pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		logic        err;
		int          polls;
		polls = 0;
		apb_read(ADDR_STATUS, st, err);
		while (st[0] && polls < POLL_LIMIT)
		begin
			apb_read(ADDR_STATUS, st, err);
			polls = polls + 1;
		end
		if (st[0])
		begin
			$display("%s: the busy flag never cleared", cur_test);
			errors      = errors + 1;
			test_errors = test_errors + 1;
		end
	endtask

	task automatic launch_frame(input pat_e pat, input logic [23:0] color, output logic err);
		logic e;
		apb_write(ADDR_SIZE, {4'h0, 12'(FRAME_V), 4'h0, 12'(FRAME_H)}, e);
		apb_write(ADDR_PATTERN, {6'h0, pat, color}, e);
		apb_write(ADDR_CTRL, 32'h4, err);
	endtask

	// One csx rise per frame means csx stayed low between beats
	task automatic check_frame(input int base, input int rises, input pat_e pat,
		input logic [23:0] color);
		logic [23:0] exp;
		int          idx;
		int          x;
		int          y;
		compare("frame bytes", 32'(FRAME_BYTES), 32'(u_model.wr_q.size() - base));
		compare("csx rises", 32'd1, 32'(u_model.csx_rises - rises));
		if (u_model.wr_q.size() == base + FRAME_BYTES)
		begin
			idx = base;
			for (y = 0; y < FRAME_V; y++)
			begin
				for (x = 0; x < FRAME_H; x++)
				begin
					exp = expected_rgb(x, y, pat, color);
					compare("red", 32'({1'b1, exp[23:16]}), 32'(u_model.wr_q[idx]));
					compare("green", 32'({1'b1, exp[15:8]}), 32'(u_model.wr_q[idx + 1]));
					compare("blue", 32'({1'b1, exp[7:0]}), 32'(u_model.wr_q[idx + 2]));
					idx = idx + 3;
				end
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------
	task automatic test_reset();
		logic [31:0] rd;
		logic        err;
		start_test("reset");
		compare("csx", 32'h1, 32'(pins.csx));
		compare("rdx", 32'h1, 32'(pins.rdx));
		compare("wrx", 32'h1, 32'(pins.wrx));
		compare("dcx", 32'h1, 32'(pins.dcx));
		compare("data_oe", 32'h1, 32'(pins.data_oe));
		compare("data_out", 32'h0, 32'(pins.data_out));
		apb_read(ADDR_STATUS, rd, err);
		compare("status", 32'h0, rd);
		end_test();
	endtask

	task automatic test_cmd_write();
		logic       err;
		logic [7:0] cmd;
		int         base;
		int         dc;
		start_test("cmd_write");
		for (dc = 0; dc < 2; dc++)
		begin
			rng  = xorshift32(rng);
			cmd  = rng[7:0];
			base = u_model.wr_q.size();
			apb_write(ADDR_CMD, {23'h0, dc[0], cmd}, err);
			apb_write(ADDR_CTRL, 32'h1, err);
			compare("launch pslverr", 32'h0, 32'(err));
			wait_idle();
			compare("byte count", 32'd1, 32'(u_model.wr_q.size() - base));
			if (u_model.wr_q.size() == base + 1)
				compare("dcx and byte", 32'({dc[0], cmd}), 32'(u_model.wr_q[base]));
			compare("csx after", 32'h1, 32'(pins.csx));
		end
		end_test();
	endtask

	task automatic test_reg_read();
		logic [31:0] rd;
		logic        err;
		int          base;
		int          rbase;
		start_test("reg_read");
		base  = u_model.wr_q.size();
		rbase = u_model.rd_cycles;
		apb_write(ADDR_CTRL, 32'h2, err);
		compare("launch pslverr", 32'h0, 32'(err));
		wait_idle();
		apb_read(ADDR_STATUS, rd, err);
		compare("read byte", 32'(RD_VALUE), 32'(rd[15:8]));
		compare("write strobes", 32'd0, 32'(u_model.wr_q.size() - base));
		compare("rdx low cycles", 32'(RD_LOW_CYCLES), 32'(u_model.rd_cycles - rbase));
		compare("data_oe high under rdx", 32'h0, 32'(u_model.oe_bad));
		end_test();
	endtask

	task automatic test_frame(input pat_e pat);
		logic        err;
		logic [23:0] color;
		int          base;
		int          rises;
		start_test($sformatf("frame_%s", pat.name()));
		rng   = xorshift32(rng);
		color = rng[23:0];
		base  = u_model.wr_q.size();
		rises = u_model.csx_rises;
		launch_frame(pat, color, err);
		compare("launch pslverr", 32'h0, 32'(err));
		wait_idle();
		check_frame(base, rises, pat, color);
		end_test();
	endtask

	task automatic test_busy();
		logic [31:0] rd;
		logic        err;
		logic [23:0] color;
		int          base;
		int          rises;
		start_test("busy_protect");
		rng   = xorshift32(rng);
		color = rng[23:0];
		base  = u_model.wr_q.size();
		rises = u_model.csx_rises;
		launch_frame(PAT_SOLID, color, err);
		// Command launch while the frame runs must be refused
		apb_write(ADDR_CTRL, 32'h1, err);
		compare("ctrl while busy pslverr", 32'h1, 32'(err));
		wait_idle();
		check_frame(base, rises, PAT_SOLID, color);
		apb_read(ADDR_BAD, rd, err);
		compare("unmapped pslverr", 32'h1, 32'(err));
		end_test();
	endtask

	// ------------------------------------------------------------------
	// Run control
	// ------------------------------------------------------------------
	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge pclk);
		$display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYC);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		rst_n       = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = 8'h00;
		pwdata      = 32'h0;
		rng         = 32'h4d2e_924b;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		cur_test    = "none";
		repeat (10) @(posedge pclk);
		rst_n <= 1'b1;
		@(posedge pclk);
		test_reset();
		test_cmd_write();
		test_reg_read();
		test_frame(PAT_SOLID);
		test_frame(PAT_HRAMP);
		test_frame(PAT_CHECKER);
		test_frame(PAT_BORDER);
		test_busy();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* mcu_panel.f */
design/panel_pkg.sv
design/mcu_bus_pkg.sv
design/panel_regs.sv
design/pattern_gen.sv
design/beat_serializer.sv
design/mcu_bus_engine.sv
design/mcu_panel_top.sv
test/panel_model.sv
test/tb_mcu_panel.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the panel driver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --top-module tb_mcu_panel -f mcu_panel.f \
	-o sim_mcu_panel > build.log 2>&1 &&
	./obj_dir/sim_mcu_panel > sim.log 2>&1 ||
	{ echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; } ||
	{ echo "simulation passed"; exit 0; }
